//--- build.f
hw/lane_pkg.sv
hw/msg_steer.sv
hw/lane_queue.sv
hw/lane_merge.sv
hw/lane_switch.sv
dv/clk_gen.sv
dv/lane_switch_props.sv
dv/lane_switch_tb.sv

//--- dv/clk_gen.sv
// Testbench clock and reset source
// 8 ns clock, reset held low for the first 16 cycles

`timescale 1ns/10ps

module clk_gen (
  output logic clk,
  output logic reset
);

  // Half period of 4 ns gives the 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Active-low reset, released on a rising edge like any other input
  initial begin
    reset = 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b1;
  end

endmodule

//--- dv/lane_switch_props.sv
// Concurrent properties on the lane queue state
// Bound into every lane_queue instance from the testbench

`timescale 1ns/10ps

module lane_switch_props
  import lane_pkg::*;
#(
  parameter logic [3:0] queue_kind = QUEUE_NORMAL
)(
  input logic                clk,
  input logic                reset,
  input logic                enq_valid,
  input logic                enq_ready,
  input logic                deq_valid,
  input logic                deq_ready,
  input logic [PTR_BITS:0]   free_entries
);

  localparam bit BYPASS_EN = |(queue_kind & QUEUE_BYPASS);
  localparam logic [PTR_BITS:0] DEPTH_COUNT = LANE_DEPTH[PTR_BITS:0];

  // Entries held in storage, counted from the handshakes on both ports
  // A bypass or pipe cycle moves one word in and one out and keeps the count
  logic [PTR_BITS:0] held;

  always_ff @(posedge clk) begin
    if (!reset) begin
      held <= '0;
    end else if (enq_valid && enq_ready && !(deq_valid && deq_ready)) begin
      held <= held + 1'b1;
    end else if (deq_valid && deq_ready && !(enq_valid && enq_ready)) begin
      held <= held - 1'b1;
    end
  end

  // An empty queue shows a valid only while the input bypasses the storage
  no_valid_when_empty: assert property (
    @(posedge clk) disable iff (!reset)
      (held != '0) || !deq_valid || (BYPASS_EN && enq_valid)
  ) else $error("lane queue raised deq_valid while empty");

  // Only the pipe kind may take a new entry while full
  no_ready_when_full: assert property (
    @(posedge clk) disable iff (!reset)
      (queue_kind != QUEUE_NORMAL) || (held != DEPTH_COUNT) || !enq_ready
  ) else $error("normal lane queue raised enq_ready while full");

  // The free count is the depth minus what is held, so it never exceeds the depth
  free_within_depth: assert property (
    @(posedge clk) disable iff (!reset)
      free_entries == DEPTH_COUNT - held
  ) else $error("lane queue free count does not match the held entries");

endmodule

//--- dv/lane_switch_tb.sv
// Testbench for the four-lane message switch
// Stimulus table, per-lane scoreboard with a grant model, watchdog and report

`timescale 1ns/10ps

module lane_switch_tb
  import lane_pkg::*;
;

  localparam int CLK_PERIOD   = 8;
  localparam int TABLE_LEN    = 25;
  localparam int WATCHDOG_NS  = (TABLE_LEN * 40 + 16) * CLK_PERIOD;
  localparam int T_RESET      = 0;
  localparam int T_ORDER      = 1;
  localparam int T_BACK       = 2;
  localparam int T_RR         = 3;
  localparam int T_DRAIN      = 4;
  localparam int FULL_LANE    = 2;
  localparam int OTHER_LANE   = 1;

  logic                 clk;
  logic                 reset;
  logic                 in_valid;
  logic                 in_ready;
  logic [MSG_BITS-1:0]  in_msg;
  logic                 in_domain;
  logic [LANE_BITS-1:0] in_lane;
  logic                 out_valid;
  logic                 out_ready;
  logic [MSG_BITS-1:0]  out_msg;
  logic                 out_domain;
  logic [LANE_BITS-1:0] out_lane;

  // Stimulus table, one row per message with its test and out_ready level
  int                   tbl_test   [TABLE_LEN];
  logic [LANE_BITS-1:0] tbl_lane   [TABLE_LEN];
  logic                 tbl_domain [TABLE_LEN];
  logic [MSG_BITS-1:0]  tbl_data   [TABLE_LEN];
  logic                 tbl_ready  [TABLE_LEN];
  string test_names [5] = '{"reset", "order", "backpressure", "round_robin", "drain"};

  // Expected words per lane, domain above payload, plus the grant pointer model
  logic [MSG_BITS:0]    sb [NUM_LANES][$];
  logic [LANE_BITS-1:0] model_ptr;
  integer seed;
  int     n_entries;
  int     errors;
  int     checks;
  int     errs_at_start;
  int     tests_run;
  int     tests_bad;
  string  cur_test;

  clk_gen clk_gen_i (.clk(clk), .reset(reset));

  lane_switch lane_switch_i (
    .clk(clk), .reset(reset),
    .in_valid(in_valid), .in_ready(in_ready), .in_msg(in_msg),
    .in_domain(in_domain), .in_lane(in_lane),
    .out_valid(out_valid), .out_ready(out_ready), .out_msg(out_msg),
    .out_domain(out_domain), .out_lane(out_lane)
  );

  bind lane_queue lane_switch_props #(.queue_kind(queue_kind)) lane_switch_props_i (
    .clk(clk), .reset(reset), .enq_valid(enq_valid), .enq_ready(enq_ready),
    .deq_valid(deq_valid), .deq_ready(deq_ready), .free_entries(free_entries)
  );

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED test=%s %s expected=%0h actual=%0h", cur_test, what,
               expected, actual);
    end
  endtask

  task automatic add_entry(input int test, input int lane, input logic rdy);
    tbl_test[n_entries]   = test;
    tbl_lane[n_entries]   = LANE_BITS'(lane);
    tbl_domain[n_entries] = 1'($random(seed));
    tbl_data[n_entries]   = MSG_BITS'($random(seed));
    tbl_ready[n_entries]  = rdy;
    n_entries++;
  endtask

  // Random traffic first, then one lane filled and the others preloaded
  task automatic build_table();
    seed = 28288;
    n_entries = 0;
    for (int i = 0; i < 12; i++) add_entry(T_ORDER, $random(seed) & 3, 1'b1);
    for (int i = 0; i < LANE_DEPTH; i++) add_entry(T_BACK, FULL_LANE, 1'b0);
    for (int i = 0; i < 3; i++) add_entry(T_RR, 0, 1'b0);
    for (int i = 0; i < 2; i++) add_entry(T_RR, 1, 1'b0);
    for (int i = 0; i < 4; i++) add_entry(T_RR, 3, 1'b0);
  endtask

  function automatic int pending_count();
    int n;
    n = 0;
    for (int l = 0; l < NUM_LANES; l++) n += sb[l].size();
    return n;
  endfunction

  // First lane with a pending message at or after the pointer, cyclic order
  function automatic logic [LANE_BITS-1:0] model_grant();
    logic [LANE_BITS-1:0] l;
    model_grant = model_ptr;
    for (int off = NUM_LANES - 1; off >= 0; off--) begin
      l = model_ptr + LANE_BITS'(off);
      if (sb[l].size() != 0) model_grant = l;
    end
  endfunction

  // Holds one table row on the input until the DUT takes it
  task automatic send_entry(input int idx);
    in_valid  <= 1'b1;
    in_lane   <= tbl_lane[idx];
    in_msg    <= tbl_data[idx];
    in_domain <= tbl_domain[idx];
    out_ready <= tbl_ready[idx];
    do @(posedge clk); while (!in_ready);
  endtask

  task automatic probe_ready(input int lane, input logic expected);
    in_valid <= 1'b0;
    in_lane  <= LANE_BITS'(lane);
    @(posedge clk);
    check_value($sformatf("in_ready lane %0d", lane), 32'(expected), 32'(in_ready));
  endtask

  // Scoreboard is read on the falling edge where the monitor leaves it alone
  task automatic wait_drain();
    do @(negedge clk); while (pending_count() != 0);
    @(posedge clk);
  endtask

  task automatic start_test(input int t);
    cur_test = test_names[t];
    errs_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != errs_at_start) tests_bad++;
    $display("test %-12s %0d mismatches", cur_test, errors - errs_at_start);
  endtask

  // ----------------------------------------------------------
  // Output monitor and scoreboard
  // ----------------------------------------------------------

  // Outputs are compared before inputs are recorded, so a message never
  // meets itself on the edge it was accepted
  always @(posedge clk) begin : monitor
    logic [LANE_BITS-1:0] exp_lane;
    logic [MSG_BITS:0]    exp_word;
    if (!reset) begin
      model_ptr = '0;
    end else begin
      check_value("out_valid", 32'(pending_count() != 0), 32'(out_valid));
      if (out_valid && out_ready) begin
        exp_lane = model_grant();
        check_value("out_lane", 32'(exp_lane), 32'(out_lane));
        if (sb[exp_lane].size() == 0) begin
          errors++;
          $display("output on lane %0d with no message pending in %s", out_lane, cur_test);
        end else begin
          exp_word = sb[exp_lane].pop_front();
          check_value("out_msg", 32'(exp_word[MSG_BITS-1:0]), 32'(out_msg));
          check_value("out_domain", 32'(exp_word[MSG_BITS]), 32'(out_domain));
        end
        model_ptr = exp_lane + 1'b1;
      end
      if (in_valid && in_ready) sb[in_lane].push_back({in_domain, in_msg});
    end
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------

  initial begin : main_seq
    int idx;
    in_valid  = 1'b0;
    in_msg    = '0;
    in_domain = 1'b0;
    in_lane   = '0;
    out_ready = 1'b0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    tests_bad = 0;
    cur_test  = "reset";
    build_table();
    wait (reset == 1'b1);
    @(posedge clk);

    start_test(T_RESET);
    check_value("out_valid", 32'd0, 32'(out_valid));
    for (int l = 0; l < NUM_LANES; l++) probe_ready(l, 1'b1);
    end_test();

    idx = 0;
    for (int t = T_ORDER; t <= T_RR; t++) begin
      start_test(t);
      while (idx < n_entries && tbl_test[idx] == t) begin
        send_entry(idx);
        idx++;
      end
      in_valid <= 1'b0;
      if (t == T_BACK) begin
        // The full lane now refuses while a neighbour still has room
        probe_ready(FULL_LANE, 1'b0);
        probe_ready(OTHER_LANE, 1'b1);
      end else begin
        out_ready <= 1'b1;
        wait_drain();
      end
      end_test();
    end

    start_test(T_DRAIN);
    check_value("out_valid", 32'd0, 32'(out_valid));
    for (int l = 0; l < NUM_LANES; l++) probe_ready(l, 1'b1);
    end_test();

    $display("summary: %0d tests run, %0d with errors, %0d checks, %0d mismatches",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

endmodule

//--- hw/lane_merge.sv
// Round-robin merge of the lane queues onto the output port
// Rotating-priority grant, output mux and grant pointer

`timescale 1ns/10ps

module lane_merge
  import lane_pkg::*;
(
  input  logic                               clk,
  input  logic                               reset,

  // Dequeue side of every lane queue
  input  logic [NUM_LANES-1:0]               deq_valid,
  output logic [NUM_LANES-1:0]               deq_ready,
  input  logic [NUM_LANES-1:0][MSG_BITS-1:0] deq_msg,
  input  logic [NUM_LANES-1:0]               deq_domain,

  // Single output port
  output logic                               out_valid,
  input  logic                               out_ready,
  output logic [MSG_BITS-1:0]                out_msg,
  output logic                               out_domain,
  output logic [LANE_BITS-1:0]               out_lane
);

  // Lane that holds top priority in the next search
  logic [LANE_BITS-1:0] grant_ptr;
  logic [LANE_BITS-1:0] grant;
  logic [LANE_BITS-1:0] cand;
  logic                 found;

  // ----------------------------------------------------------
  // Rotating-priority search
  // ----------------------------------------------------------

  // Walk the lanes in cyclic order starting at the pointer
  // The first valid lane on the way wins the grant
  // Lane indices wrap through the LANE_BITS width of cand
  always_comb begin
    grant = grant_ptr;
    found = 1'b0;
    cand  = grant_ptr;
    for (int off = 0; off < NUM_LANES; off++) begin
      cand = grant_ptr + LANE_BITS'(off);
      if (!found && deq_valid[cand]) begin
        grant = cand;
        found = 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Output mux and ready return
  // ----------------------------------------------------------

  // The output is valid as soon as any lane is valid
  assign out_valid  = found;
  assign out_msg    = deq_msg[grant];
  assign out_domain = deq_domain[grant];
  assign out_lane   = grant;

  // Only the granted lane sees the consumer's ready
  always_comb begin
    deq_ready        = '0;
    deq_ready[grant] = out_ready && found;
  end

  // The pointer moves past the served lane on each transfer
  always_ff @(posedge clk) begin
    if (!reset) begin
      grant_ptr <= '0;
    end else if (out_valid && out_ready) begin
      grant_ptr <= grant + 1'b1;
    end
  end

endmodule

//--- hw/lane_pkg.sv
// Shared constants for the four-lane message switch
// Lane count, queue depth, field widths and queue-kind codes

package lane_pkg;

  // ----------------------------------------------------------
  // Switch geometry
  // ----------------------------------------------------------

  // Number of lane queues behind the steering block
  localparam int NUM_LANES = 4;

  // Entries held by each lane queue
  localparam int LANE_DEPTH = 4;

  // Width of the lane number carried with each message
  localparam int LANE_BITS = 2;

  // Width of the enqueue and dequeue pointers inside a lane queue
  localparam int PTR_BITS = 2;

  // Width of the message payload
  localparam int MSG_BITS = 16;

  // ----------------------------------------------------------
  // Queue kinds
  // ----------------------------------------------------------

  // Pipe and bypass are independent bits and may be combined
  // A pipe queue accepts a new entry while full if the consumer drains one
  // A bypass queue hands the input straight to the output while empty
  localparam logic [3:0] QUEUE_NORMAL = 4'b0000;
  localparam logic [3:0] QUEUE_PIPE   = 4'b0001;
  localparam logic [3:0] QUEUE_BYPASS = 4'b0010;

endpackage

//--- hw/lane_queue.sv
// Circular-buffer lane queue with valid/ready on both sides
// Static pipe and bypass paths are chosen through queue_kind

`timescale 1ns/10ps

module lane_queue
  import lane_pkg::*;
#(
  parameter logic [3:0] queue_kind = QUEUE_NORMAL
)(
  input  logic                clk,
  input  logic                reset,

  // Enqueue side from the steering block
  input  logic                enq_valid,
  output logic                enq_ready,
  input  logic [MSG_BITS-1:0] enq_msg,
  input  logic                enq_domain,

  // Dequeue side toward the merge block
  output logic                deq_valid,
  input  logic                deq_ready,
  output logic [MSG_BITS-1:0] deq_msg,
  output logic                deq_domain,

  // Count of empty entries, between zero and LANE_DEPTH
  output logic [PTR_BITS:0]   free_entries
);

  // Pipe and bypass enables decoded once from the queue kind
  localparam bit PIPE_EN   = |(queue_kind & QUEUE_PIPE);
  localparam bit BYPASS_EN = |(queue_kind & QUEUE_BYPASS);

  // Last pointer value before the wrap back to entry zero
  localparam logic [PTR_BITS-1:0] LAST_PTR    = PTR_BITS'(LANE_DEPTH - 1);
  localparam logic [PTR_BITS:0]   DEPTH_COUNT = LANE_DEPTH[PTR_BITS:0];

  // ----------------------------------------------------------
  // Control state
  // ----------------------------------------------------------

  logic [PTR_BITS-1:0] enq_ptr;
  logic [PTR_BITS-1:0] deq_ptr;
  logic [PTR_BITS-1:0] enq_ptr_inc;
  logic [PTR_BITS-1:0] deq_ptr_inc;
  logic                full;
  logic                empty;
  logic                do_enq;
  logic                do_deq;
  logic                do_pipe;
  logic                do_bypass;
  logic                write_en;

  // Equal pointers mean empty unless the full flag is set
  assign empty = !full && (enq_ptr == deq_ptr);

  // Ready and valid come from the state
  // The pipe path lets a waiting consumer free a slot in the same cycle
  // The bypass path shows the input at the output while nothing is stored
  assign enq_ready = !full || (PIPE_EN && full && deq_ready);
  assign deq_valid = !empty || (BYPASS_EN && empty && enq_valid);

  assign do_enq    = enq_valid && enq_ready;
  assign do_deq    = deq_valid && deq_ready;
  assign do_pipe   = PIPE_EN && full && do_enq && do_deq;
  assign do_bypass = BYPASS_EN && empty && do_enq && do_deq;

  // A message that bypasses the storage is never written
  assign write_en = do_enq && !do_bypass;

  // Pointers wrap at LANE_DEPTH and not at the pointer width
  assign enq_ptr_inc = (enq_ptr == LAST_PTR) ? '0 : enq_ptr + 1'b1;
  assign deq_ptr_inc = (deq_ptr == LAST_PTR) ? '0 : deq_ptr + 1'b1;

  always_ff @(posedge clk) begin
    if (!reset) begin
      enq_ptr <= '0;
      deq_ptr <= '0;
      full    <= 1'b0;
    end else begin
      if (write_en) begin
        enq_ptr <= enq_ptr_inc;
      end
      if (do_deq && !do_bypass) begin
        deq_ptr <= deq_ptr_inc;
      end
      // Full is set when the last free slot fills without a drain
      if (do_enq && !do_deq && (enq_ptr_inc == deq_ptr)) begin
        full <= 1'b1;
      end else if (do_deq && full && !do_pipe) begin
        full <= 1'b0;
      end
    end
  end

  // Free entries from the pointer distance
  // Equal pointers give the whole depth, since full is handled first
  always_comb begin
    if (full) begin
      free_entries = '0;
    end else if (enq_ptr >= deq_ptr) begin
      free_entries = DEPTH_COUNT - {1'b0, enq_ptr - deq_ptr};
    end else begin
      free_entries = {1'b0, deq_ptr - enq_ptr};
    end
  end

  // ----------------------------------------------------------
  // Storage and bypass mux
  // ----------------------------------------------------------

  // Each entry holds the domain label above the payload
  logic [MSG_BITS:0] store [LANE_DEPTH];
  logic [MSG_BITS:0] read_word;

  always_ff @(posedge clk) begin
    if (write_en) begin
      store[enq_ptr] <= {enq_domain, enq_msg};
    end
  end

  // Empty bypass queues present the input word directly
  always_comb begin
    if (BYPASS_EN && empty) begin
      read_word = {enq_domain, enq_msg};
    end else begin
      read_word = store[deq_ptr];
    end
  end

  assign deq_domain = read_word[MSG_BITS];
  assign deq_msg    = read_word[MSG_BITS-1:0];

endmodule

//--- hw/lane_switch.sv
// Top level of the four-lane message switch
// Steering block, generated lane queues and round-robin merge

`timescale 1ns/10ps

module lane_switch
  import lane_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,

  // Input port
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic [MSG_BITS-1:0]  in_msg,
  input  logic                 in_domain,
  input  logic [LANE_BITS-1:0] in_lane,

  // Output port
  output logic                 out_valid,
  input  logic                 out_ready,
  output logic [MSG_BITS-1:0]  out_msg,
  output logic                 out_domain,
  output logic [LANE_BITS-1:0] out_lane
);

  logic [NUM_LANES-1:0]               enq_valid;
  logic [NUM_LANES-1:0]               enq_ready;
  logic [NUM_LANES-1:0]               deq_valid;
  logic [NUM_LANES-1:0]               deq_ready;
  logic [NUM_LANES-1:0][MSG_BITS-1:0] deq_msg;
  logic [NUM_LANES-1:0]               deq_domain;

  // Steering picks one lane by in_lane
  msg_steer msg_steer_i (
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_lane   (in_lane),
    .enq_valid (enq_valid),
    .enq_ready (enq_ready)
  );

  // ----------------------------------------------------------
  // Lane queues
  // ----------------------------------------------------------

  // Message and domain go to every lane and only the valid differs
  // The free count stays inside each lane for the bound properties
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    lane_queue #(.queue_kind(QUEUE_NORMAL)) lane_queue_i (
      .clk          (clk),
      .reset        (reset),
      .enq_valid    (enq_valid[i]),
      .enq_ready    (enq_ready[i]),
      .enq_msg      (in_msg),
      .enq_domain   (in_domain),
      .deq_valid    (deq_valid[i]),
      .deq_ready    (deq_ready[i]),
      .deq_msg      (deq_msg[i]),
      .deq_domain   (deq_domain[i]),
      .free_entries ()
    );
  end

  // Round-robin drain onto the output port
  lane_merge lane_merge_i (
    .clk        (clk),
    .reset      (reset),
    .deq_valid  (deq_valid),
    .deq_ready  (deq_ready),
    .deq_msg    (deq_msg),
    .deq_domain (deq_domain),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_msg    (out_msg),
    .out_domain (out_domain),
    .out_lane   (out_lane)
  );

endmodule

//--- hw/msg_steer.sv
// Input steering for the lane switch
// Decodes the lane number into per-lane valids and returns the chosen ready

`timescale 1ns/10ps

module msg_steer
  import lane_pkg::*;
(
  // Source side of the single input port
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic [LANE_BITS-1:0] in_lane,

  // One valid and one ready per lane queue
  output logic [NUM_LANES-1:0] enq_valid,
  input  logic [NUM_LANES-1:0] enq_ready
);

  // ----------------------------------------------------------
  // Valid decode
  // ----------------------------------------------------------

  // Only the lane named by in_lane sees the valid
  // All other lanes keep their enqueue valid low
  always_comb begin
    enq_valid = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (in_lane == LANE_BITS'(i)) begin
        enq_valid[i] = in_valid;
      end
    end
  end

  // ----------------------------------------------------------
  // Ready select
  // ----------------------------------------------------------

  // The source sees the ready of the addressed lane only
  // This does not depend on in_valid, so the source can sample it early
  // A full lane stalls the source even if another lane has room
  always_comb begin
    in_ready = enq_ready[in_lane];
  end

  // Message and domain bits do not pass through here
  // The top level broadcasts them to every lane queue

endmodule

//--- run.sh
#!/usr/bin/env bash
# Compile and run the lane switch testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f build.f \
  --top-module lane_switch_tb \
  -o lane_switch_sim

./obj_dir/lane_switch_sim | tee sim.log

if grep -q "all tests passed" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi
